//--- pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// --------------------
	// Host pipe sizing
	// --------------------
	localparam int FIFO_DEPTH      = 64; // Words per pipe FIFO
	localparam int BLOCK_SIZE      = 16; // Words per host block transfer
	localparam int BUFFER_HEADROOM = 4;  // Covers the lag of the ready flag
	localparam int OUT_RESERVE     = 2;  // Output slots kept for results in flight

	// One host pipe word
	typedef logic [31:0] pipe_word_t;

	// Occupancy from 0 up to FIFO_DEPTH inclusive
	typedef logic [$clog2(FIFO_DEPTH + 1) - 1:0] pipe_count_t;

	// Host write strobe with its word
	typedef struct packed {
		logic       write;
		pipe_word_t data;
	} pipe_in_t;

endpackage

`default_nettype wire

//--- pool_pkg.sv
`default_nettype none

package pool_pkg;

	// --------------------
	// Window sizes
	// --------------------
	localparam int MAX_WINDOW = 9;   // 3x3 max pool
	localparam int AVE_WINDOW = 169; // 13x13 average pool

	// Unsigned feature-map element
	typedef logic [15:0] elem_t;

	// Command opcodes, other encodings are treated as unknown
	typedef enum logic [3:0] {
		OP_MAXPOOL = 4'd1,
		OP_AVEPOOL = 4'd2
	} pool_op_e;

	// Command word as it arrives on the input pipe
	typedef struct packed {
		pool_op_e    opcode;   // 31:28
		logic [11:0] reserved; // 27:16
		logic [15:0] windows;  // 15:0, number of windows that follow
	} pool_cmd_t;

	// One element handed to a pooling core
	typedef struct packed {
		logic  valid;
		logic  last;  // Final element of a window
		elem_t value;
	} elem_beat_t;

endpackage

`default_nettype wire

//--- pipe_fifo.sv
`default_nettype none

module pipe_fifo #(
	parameter int DEPTH = pipe_pkg::FIFO_DEPTH
) (
	input  logic                  okClk,
	input  logic                  arst_n,
	input  logic                  push,
	input  pipe_pkg::pipe_word_t  wdata,
	input  logic                  pop,
	output pipe_pkg::pipe_word_t  rdata,
	output logic                  empty,
	output pipe_pkg::pipe_count_t count
);

	localparam int AW = $clog2(DEPTH);

	pipe_pkg::pipe_word_t mem [DEPTH];
	logic [AW-1:0]        wr_ptr;
	logic [AW-1:0]        rd_ptr;

	// Show-ahead head word
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);

	always_ff @(posedge okClk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Idle or push with pop
			endcase
		end
	end

	// Handshake misuse by either side
	a_no_overflow : assert property (@(posedge okClk) disable iff (!arst_n)
		push |-> (count != pipe_pkg::pipe_count_t'(DEPTH)));

	a_no_underflow : assert property (@(posedge okClk) disable iff (!arst_n)
		pop |-> !empty);

endmodule

`default_nettype wire

//--- host_pipe_bridge.sv
`default_nettype none

module host_pipe_bridge (
	input  logic                  okClk,
	input  logic                  arst_n,
	// Host side
	input  pipe_pkg::pipe_in_t    pipe_in,
	output logic                  pipe_in_ready,
	input  logic                  pipe_out_read,
	output pipe_pkg::pipe_word_t  pipe_out_data,
	output logic                  pipe_out_empty,
	output pipe_pkg::pipe_count_t pipe_out_count,
	output logic                  pipe_out_ready,
	// Controller side
	output pipe_pkg::pipe_word_t  in_word,
	output logic                  in_empty,
	input  logic                  in_pop,
	input  logic                  res_push,
	input  pipe_pkg::pipe_word_t  res_word,
	output logic                  out_room
);

	pipe_pkg::pipe_count_t in_count;

	// --------------------
	// Pipe FIFOs
	// --------------------
	pipe_fifo #(.DEPTH(pipe_pkg::FIFO_DEPTH)) u_in_fifo (
		.okClk (okClk),
		.arst_n(arst_n),
		.push  (pipe_in.write),
		.wdata (pipe_in.data),
		.pop   (in_pop),
		.rdata (in_word),
		.empty (in_empty),
		.count (in_count)
	);

	pipe_fifo #(.DEPTH(pipe_pkg::FIFO_DEPTH)) u_out_fifo (
		.okClk (okClk),
		.arst_n(arst_n),
		.push  (res_push),
		.wdata (res_word),
		.pop   (pipe_out_read),
		.rdata (pipe_out_data),
		.empty (pipe_out_empty),
		.count (pipe_out_count)
	);

	// Keeps space for results already on their way
	assign out_room = (pipe_out_count <=
		pipe_pkg::pipe_count_t'(pipe_pkg::FIFO_DEPTH - pipe_pkg::OUT_RESERVE));

	// --------------------
	// Block throttle
	// --------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			pipe_in_ready  <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			// A whole block must fit, plus headroom for the flag lag
			pipe_in_ready  <= (in_count <= pipe_pkg::pipe_count_t'(pipe_pkg::FIFO_DEPTH -
				pipe_pkg::BUFFER_HEADROOM - pipe_pkg::BLOCK_SIZE));
			pipe_out_ready <= (pipe_out_count >= pipe_pkg::pipe_count_t'(pipe_pkg::BLOCK_SIZE));
		end
	end

endmodule

`default_nettype wire

//--- layer_ctrl.sv
`default_nettype none

module layer_ctrl (
	input  logic                 okClk,
	input  logic                 arst_n,
	// Input pipe head
	input  pipe_pkg::pipe_word_t in_word,
	input  logic                 in_empty,
	output logic                 in_pop,
	input  logic                 out_room,
	// Core element streams
	output pool_pkg::elem_beat_t max_beat,
	output pool_pkg::elem_beat_t ave_beat,
	// Core results
	input  logic                 max_res_valid,
	input  pool_pkg::elem_t      max_res,
	input  logic                 ave_res_valid,
	input  pool_pkg::elem_t      ave_res,
	// Output pipe write
	output logic                 res_push,
	output pipe_pkg::pipe_word_t res_word
);

	typedef enum logic {
		IDLE,
		STREAM
	} state_e;

	state_e              state;
	pool_pkg::pool_cmd_t cmd;
	pool_pkg::pool_op_e  cur_op;     // Opcode of the running command
	logic [15:0]         win_total;
	logic [15:0]         win_cnt;
	logic [7:0]          elem_cnt;
	logic [7:0]          elem_last_idx;
	logic                cmd_ok;
	logic                fwd;
	logic                last_elem;
	pool_pkg::elem_t     res_sel;

	assign cmd = pool_pkg::pool_cmd_t'(in_word);

	// Known opcode with at least one window
	assign cmd_ok = ((cmd.opcode == pool_pkg::OP_MAXPOOL) ||
		(cmd.opcode == pool_pkg::OP_AVEPOOL)) && (cmd.windows != 16'd0);

	assign elem_last_idx = (cur_op == pool_pkg::OP_AVEPOOL) ?
		8'(pool_pkg::AVE_WINDOW - 1) : 8'(pool_pkg::MAX_WINDOW - 1);

	// One element per cycle, stalled by an empty pipe or a full output
	assign fwd       = (state == STREAM) && !in_empty && out_room;
	assign last_elem = (elem_cnt == elem_last_idx);

	// Commands are consumed even when they turn out to be no-ops
	assign in_pop = (state == IDLE) ? !in_empty : fwd;

	// --------------------
	// Element routing
	// --------------------
	always_comb begin
		max_beat.valid = fwd && (cur_op == pool_pkg::OP_MAXPOOL);
		max_beat.last  = last_elem;
		max_beat.value = in_word[15:0];
		ave_beat.valid = fwd && (cur_op == pool_pkg::OP_AVEPOOL);
		ave_beat.last  = last_elem;
		ave_beat.value = in_word[15:0];
	end

	// --------------------
	// Command FSM
	// --------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			cur_op    <= pool_pkg::OP_MAXPOOL;
			win_total <= '0;
			win_cnt   <= '0;
			elem_cnt  <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (!in_empty && cmd_ok) begin
						state     <= STREAM;
						cur_op    <= cmd.opcode;
						win_total <= cmd.windows;
						win_cnt   <= '0;
						elem_cnt  <= '0;
					end
				end
				STREAM: begin
					if (fwd) begin
						if (last_elem) begin
							elem_cnt <= '0;
							if (win_cnt == win_total - 16'd1) begin
								state <= IDLE; // Last window of the command
							end else begin
								win_cnt <= win_cnt + 16'd1;
							end
						end else begin
							elem_cnt <= elem_cnt + 8'd1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Result merge, one core active per command
	assign res_sel  = max_res_valid ? max_res : ave_res;
	assign res_push = max_res_valid | ave_res_valid;
	assign res_word = pipe_pkg::pipe_word_t'({16'h0000, res_sel});

	a_beat_in_stream : assert property (@(posedge okClk) disable iff (!arst_n)
		(max_beat.valid || ave_beat.valid) |-> (state == STREAM));

	// Both cores pulsing together would drop a result
	a_res_no_collide : assert property (@(posedge okClk) disable iff (!arst_n)
		!(max_res_valid && ave_res_valid));

endmodule

`default_nettype wire

//--- max_pool_3x3.sv
`default_nettype none

module max_pool_3x3 (
	input  logic                 okClk,
	input  logic                 arst_n,
	input  pool_pkg::elem_beat_t beat,
	output logic                 res_valid,
	output pool_pkg::elem_t      res
);

	logic [3:0]      beat_cnt; // Position inside the window
	pool_pkg::elem_t run_max;
	pool_pkg::elem_t max_next;

	// First element of a window restarts the maximum
	assign max_next = ((beat_cnt == 4'd0) || (beat.value > run_max)) ? beat.value : run_max;

	always_ff @(posedge okClk) begin
		if (beat.valid) begin
			run_max <= max_next;
		end
		if (beat.valid && beat.last) begin
			res <= max_next;
		end
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			beat_cnt  <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= beat.valid && beat.last; // One-cycle pulse
			if (beat.valid) begin
				beat_cnt <= beat.last ? 4'd0 : beat_cnt + 4'd1;
			end
		end
	end

	// Controller framing matches the 3x3 window
	a_last_every_window : assert property (@(posedge okClk) disable iff (!arst_n)
		beat.valid |-> (beat.last == (beat_cnt == 4'(pool_pkg::MAX_WINDOW - 1))));

endmodule

`default_nettype wire

//--- ave_pool_13x13.sv
`default_nettype none

module ave_pool_13x13 (
	input  logic                 okClk,
	input  logic                 arst_n,
	input  pool_pkg::elem_beat_t beat,
	output logic                 res_valid,
	output pool_pkg::elem_t      res
);

	// 169 * 0xFFFF still fits in 24 bits
	logic [23:0] sum;
	logic [23:0] sum_next;

	assign sum_next = sum + 24'(beat.value);

	// --------------------
	// Accumulator
	// --------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			sum       <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= beat.valid && beat.last;
			if (beat.valid) begin
				sum <= beat.last ? 24'd0 : sum_next; // Restart for the next window
			end
		end
	end

	// Floor of the window mean, constant divisor
	always_ff @(posedge okClk) begin
		if (beat.valid && beat.last) begin
			res <= pool_pkg::elem_t'(sum_next / 24'(pool_pkg::AVE_WINDOW));
		end
	end

endmodule

`default_nettype wire

//--- pool_accel_top.sv
`default_nettype none

module pool_accel_top (
	input  logic                  okClk,
	input  logic                  arst_n,
	input  pipe_pkg::pipe_in_t    pipe_in,
	output logic                  pipe_in_ready,
	input  logic                  pipe_out_read,
	output pipe_pkg::pipe_word_t  pipe_out_data,
	output logic                  pipe_out_empty,
	output pipe_pkg::pipe_count_t pipe_out_count,
	output logic                  pipe_out_ready
);

	pipe_pkg::pipe_word_t in_word;
	logic                 in_empty;
	logic                 in_pop;
	logic                 out_room;
	logic                 res_push;
	pipe_pkg::pipe_word_t res_word;
	pool_pkg::elem_beat_t max_beat;
	pool_pkg::elem_beat_t ave_beat;
	logic                 max_res_valid;
	pool_pkg::elem_t      max_res;
	logic                 ave_res_valid;
	pool_pkg::elem_t      ave_res;

	// --------------------
	// Host pipes
	// --------------------
	host_pipe_bridge u_bridge (
		.okClk         (okClk),
		.arst_n        (arst_n),
		.pipe_in       (pipe_in),
		.pipe_in_ready (pipe_in_ready),
		.pipe_out_read (pipe_out_read),
		.pipe_out_data (pipe_out_data),
		.pipe_out_empty(pipe_out_empty),
		.pipe_out_count(pipe_out_count),
		.pipe_out_ready(pipe_out_ready),
		.in_word       (in_word),
		.in_empty      (in_empty),
		.in_pop        (in_pop),
		.res_push      (res_push),
		.res_word      (res_word),
		.out_room      (out_room)
	);

	layer_ctrl u_ctrl (
		.okClk        (okClk),
		.arst_n       (arst_n),
		.in_word      (in_word),
		.in_empty     (in_empty),
		.in_pop       (in_pop),
		.out_room     (out_room),
		.max_beat     (max_beat),
		.ave_beat     (ave_beat),
		.max_res_valid(max_res_valid),
		.max_res      (max_res),
		.ave_res_valid(ave_res_valid),
		.ave_res      (ave_res),
		.res_push     (res_push),
		.res_word     (res_word)
	);

	// --------------------
	// Pooling cores
	// --------------------
	max_pool_3x3 u_max_pool (
		.okClk    (okClk),
		.arst_n   (arst_n),
		.beat     (max_beat),
		.res_valid(max_res_valid),
		.res      (max_res)
	);

	ave_pool_13x13 u_ave_pool (
		.okClk    (okClk),
		.arst_n   (arst_n),
		.beat     (ave_beat),
		.res_valid(ave_res_valid),
		.res      (ave_res)
	);

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD = 20
) (
	output logic okClk
);

	initial okClk = 1'b0;

	always #(PERIOD / 2) okClk = ~okClk; // Free running

endmodule

`default_nettype wire

//--- tb_pool_accel.sv
`default_nettype none

module tb_pool_accel;

	logic                  okClk;
	logic                  arst_n;
	pipe_pkg::pipe_in_t    pipe_in;
	logic                  pipe_in_ready;
	logic                  pipe_out_read;
	pipe_pkg::pipe_word_t  pipe_out_data;
	logic                  pipe_out_empty;
	pipe_pkg::pipe_count_t pipe_out_count;
	logic                  pipe_out_ready;

	pipe_pkg::pipe_word_t tx_q[$];  // Words waiting for the host writer
	pipe_pkg::pipe_word_t exp_q[$]; // Expected results in order
	pipe_pkg::pipe_word_t rx_q[$];  // Words popped by the host reader
	bit                   reader_paused = 1'b0;
	int                   word_total = 0;
	int                   result_idx = 0;

	tb_clk_gen #(.PERIOD(20)) u_clk (.okClk(okClk));

	pool_accel_top u_dut (
		.okClk         (okClk),
		.arst_n        (arst_n),
		.pipe_in       (pipe_in),
		.pipe_in_ready (pipe_in_ready),
		.pipe_out_read (pipe_out_read),
		.pipe_out_data (pipe_out_data),
		.pipe_out_empty(pipe_out_empty),
		.pipe_out_count(pipe_out_count),
		.pipe_out_ready(pipe_out_ready)
	);

	// --------------------
	// Reference and checks
	// --------------------
	function automatic pipe_pkg::pipe_word_t ref_pool(input logic [3:0] op,
			input pool_pkg::elem_t win[$]);
		int unsigned     sum;
		pool_pkg::elem_t best;
		sum  = 0;
		best = '0;
		foreach (win[i]) begin
			sum += win[i];
			if (win[i] > best) best = win[i];
		end
		if (op == pool_pkg::OP_MAXPOOL) return {16'h0000, best};
		return {16'h0000, pool_pkg::elem_t'(sum / pool_pkg::AVE_WINDOW)}; // Floored mean
	endfunction

	task automatic check_result(input pipe_pkg::pipe_word_t got, input pipe_pkg::pipe_word_t exp,
			input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b expected %b", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// Queues one command word, its elements and the expected results
	task automatic add_command(input logic [3:0] op, input int windows, input bit all_ones);
		pool_pkg::pool_cmd_t cmd;
		pool_pkg::elem_t     win[$];
		pool_pkg::elem_t     elem;
		int                  wsize;
		cmd.opcode   = pool_pkg::pool_op_e'(op);
		cmd.reserved = '0;
		cmd.windows  = 16'(windows);
		tx_q.push_back(pipe_pkg::pipe_word_t'(cmd));
		word_total++;
		if (op == pool_pkg::OP_MAXPOOL) wsize = pool_pkg::MAX_WINDOW;
		else if (op == pool_pkg::OP_AVEPOOL) wsize = pool_pkg::AVE_WINDOW;
		else wsize = 0; // Unknown opcode carries no elements
		for (int w = 0; (w < windows) && (wsize > 0); w++) begin
			win.delete();
			for (int e = 0; e < wsize; e++) begin
				elem = all_ones ? 16'hFFFF : pool_pkg::elem_t'($urandom());
				win.push_back(elem);
				tx_q.push_back({16'h0000, elem});
				word_total++;
			end
			exp_q.push_back(ref_pool(op, win));
		end
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0) @(negedge okClk);
	endtask

	// --------------------
	// Host side processes
	// --------------------
	initial begin : host_writer
		int burst;
		wait (arst_n === 1'b1);
		forever begin
			@(negedge okClk);
			if (pipe_in_ready && (tx_q.size() > 0)) begin
				burst = 0;
				while ((burst < pipe_pkg::BLOCK_SIZE) && (tx_q.size() > 0)) begin
					pipe_in.write = 1'b1;
					pipe_in.data  = tx_q.pop_front();
					burst++;
					@(negedge okClk);
				end
				pipe_in.write = 1'b0; // Gap before the next ready check
			end
		end
	end

	initial begin : host_reader
		forever begin
			@(negedge okClk);
			if (arst_n && !reader_paused && !pipe_out_empty) begin
				rx_q.push_back(pipe_out_data); // Head word shown ahead
				pipe_out_read = 1'b1;
			end else begin
				pipe_out_read = 1'b0;
			end
		end
	end

	initial begin : compare_results
		pipe_pkg::pipe_word_t got;
		forever begin
			@(posedge okClk);
			while (rx_q.size() > 0) begin
				got = rx_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("Extra result word %h at %0t with none outstanding", got, $time);
					$display("Simulation FAILED");
					$fatal(1, "unexpected result");
				end else begin
					check_result(got, exp_q.pop_front(), $sformatf("result %0d", result_idx));
					result_idx++;
				end
			end
		end
	end

	initial begin : out_count_monitor
		forever begin
			@(negedge okClk);
			if (arst_n) check_flag(pipe_out_count <= pipe_pkg::FIFO_DEPTH, 1'b1, "out count in range");
		end
	end

	// Bound grows with every queued word
	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge okClk);
			cycles++;
			if (cycles > (40 * word_total + 2000)) begin
				$display("Timeout: no progress after %0d cycles, %0d words queued", cycles, word_total);
				$display("Simulation FAILED");
				$fatal(1, "watchdog expired");
			end
		end
	end

	// --------------------
	// Test sequence
	// --------------------
	initial begin : main_seq
		void'($urandom(32'h3690));
		arst_n        = 1'b0;
		pipe_in       = '0;
		pipe_out_read = 1'b0;
		repeat (10) @(posedge okClk);
		@(negedge okClk);
		arst_n = 1'b1;

		// Max pool, random windows
		@(posedge okClk);
		add_command(pool_pkg::OP_MAXPOOL, 12, 1'b0);
		wait_drained();

		// Average pool, random and saturated windows
		@(posedge okClk);
		add_command(pool_pkg::OP_AVEPOOL, 3, 1'b0);
		add_command(pool_pkg::OP_AVEPOOL, 2, 1'b1);
		wait_drained();

		// Mixed stream with no-op commands in between
		@(posedge okClk);
		add_command(pool_pkg::OP_MAXPOOL, 3, 1'b0);
		add_command(pool_pkg::OP_AVEPOOL, 0, 1'b0);
		add_command(4'hF, 5, 1'b0);
		add_command(pool_pkg::OP_AVEPOOL, 2, 1'b0);
		add_command(pool_pkg::OP_MAXPOOL, 0, 1'b0);
		add_command(pool_pkg::OP_MAXPOOL, 2, 1'b0);
		wait_drained();

		// Output block ready with the reader held off
		@(posedge okClk);
		reader_paused = 1'b1;
		add_command(pool_pkg::OP_MAXPOOL, 20, 1'b0);
		@(negedge okClk);
		while (pipe_out_count < pipe_pkg::BLOCK_SIZE) begin
			check_flag(pipe_out_ready, 1'b0, "pipe_out_ready below one block");
			@(negedge okClk);
		end
		@(negedge okClk);
		check_flag(pipe_out_ready, 1'b1, "pipe_out_ready with a block waiting");
		@(posedge okClk);
		reader_paused = 1'b0;
		wait_drained();

		// Back-pressure into the input pipe
		@(posedge okClk);
		reader_paused = 1'b1;
		add_command(pool_pkg::OP_MAXPOOL, 80, 1'b0);
		@(negedge okClk);
		while (pipe_in_ready !== 1'b0) @(negedge okClk);
		repeat (100) @(negedge okClk);
		check_flag(pipe_in_ready, 1'b0, "pipe_in_ready while stalled");
		check_flag(pipe_out_count >= (pipe_pkg::FIFO_DEPTH - pipe_pkg::OUT_RESERVE), 1'b1,
			"output pipe nearly full while stalled");
		@(posedge okClk);
		reader_paused = 1'b0;
		wait_drained();

		repeat (20) @(negedge okClk);
		check_flag(pipe_out_empty, 1'b1, "output pipe empty at the end");
		if ((exp_q.size() == 0) && (rx_q.size() == 0) && (tx_q.size() == 0)) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("Words left over at the end of the run");
			$display("Simulation FAILED");
			$fatal(1, "leftover words");
		end
	end

endmodule

`default_nettype wire

//--- pool_accel.f
pipe_pkg.sv
pool_pkg.sv
pipe_fifo.sv
host_pipe_bridge.sv
layer_ctrl.sv
max_pool_3x3.sv
ave_pool_13x13.sv
pool_accel_top.sv
tb_clk_gen.sv
tb_pool_accel.sv

//--- Bender.yml
package:
  name: pool_accel

sources:
  - pipe_pkg.sv
  - pool_pkg.sv
  - pipe_fifo.sv
  - host_pipe_bridge.sv
  - layer_ctrl.sv
  - max_pool_3x3.sv
  - ave_pool_13x13.sv
  - pool_accel_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_pool_accel.sv
